/* list.f */
+incdir+.
quad_ctrl_pkg.sv
quad_ctrl_if.sv
job_sequencer.sv
pfb_row_reader.sv
pix_seq_issuer.sv
ce_execute_chain.sv
quad_bram_ctrl.sv
quad_ctrl_props.sv
quad_ctrl_tb.sv

/* quad_ctrl_tb.sv */
`timescale 1ns/10ps
`include "quad_ctrl_consts.svh"

module quad_ctrl_tb import quad_ctrl_pkg::*; ();

    // Cycles any single wait may take before the run is abandoned
    localparam int TIMEOUT  = 4000;
    localparam int NUM_JOBS = 5;

    // Job sizes as count minus one, rows at least 3
    int job_rows [NUM_JOBS] = '{3, 5, 3, 6, 4};
    int job_cols [NUM_JOBS] = '{2, 0, 7, 12, 4};

    logic clk;
    logic rst;
    dim_t num_input_cols;
    dim_t num_input_rows;
    logic job_start;
    logic job_accept;
    logic job_fetch_request;
    logic job_fetch_ack;
    logic job_fetch_complete;
    logic job_complete;
    logic job_complete_ack;
    dim_t input_row;
    dim_t input_col;
    logic pfb_rden;
    logic pix_seq_bram_rden;
    seq_addr_t pix_seq_bram_rdaddr;
    logic [`QUAD_NUM_CE-1:0] ce_execute;

    logic [31:0] rng_state = 32'hb307;
    int value_errs = 0;
    int proto_errs = 0;

    // Per-job tallies kept by the compare process
    int accept_cnt = 0;
    int fetch_cnt = 0;
    int pfb_cnt = 0;
    int seq_cnt = 0;
    int exe_cnt = 0;
    int burst_len = 0;
    int cur_cols = 0;
    // Rows read out of the prefetch buffer since reset
    int rows_read = 0;
    logic pfb_prev = 1'b0;
    logic cmpl_prev = 1'b0;
    logic req_prev = 1'b0;

    quad_bram_ctrl dut (.*);

    bind quad_bram_ctrl quad_ctrl_props u_props (
        .*,
        .seq_state (u_seq.state)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Random numbers and reference model
    ////////////////////////////////////////////////////////////////////////////
    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic int next_rand();
        rng_state = xorshift32(rng_state);
        return int'(rng_state[15:0]);
    endfunction

    // One row of cols+1 words per fetch, rows+1 fetches
    function automatic int expected_pfb_reads(input int rows, input int cols);
        return (rows + 1) * (cols + 1);
    endfunction

    // Five sequence reads per output column, one sweep per row
    function automatic int expected_seq_reads(input int rows, input int cols);
        return (rows + 1) * (cols + 1) * `QUAD_READS_PER_COL;
    endfunction

    // Address wraps once per sweep
    function automatic int expected_seq_addr(input int k, input int cols);
        return k % (`QUAD_READS_PER_COL * (cols + 1));
    endfunction

    task automatic check_count(input string what, input int got, input int want);
        if (got != want) begin
            $display("ERROR at %0t ns: %s count %0d, expected %0d", $time, what, got, want);
            value_errs++;
        end
    endtask

    task automatic finish_run();
        $display("Run finished: %0d value errors, %0d protocol errors, %0d assertion failures",
                 value_errs, proto_errs, dut.u_props.assert_fails);
        if (value_errs == 0 && proto_errs == 0 && dut.u_props.assert_fails == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    endtask

    task automatic timeout_abort(input string what);
        proto_errs++;
        $display("Timed out waiting for %s", what);
        finish_run();
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Fetch responder, random ack then random complete
    ////////////////////////////////////////////////////////////////////////////
    initial begin : fetch_responder
        int waited;
        int d;
        forever begin
            waited = 0;
            do begin
                @(negedge clk);
                waited++;
                if (waited > TIMEOUT) timeout_abort("a fetch request");
            end while (!job_fetch_request);
            d = next_rand() % 4;
            repeat (d) @(posedge clk);
            @(posedge clk);
            job_fetch_ack <= 1'b1;
            @(posedge clk);
            job_fetch_ack <= 1'b0;
            // Complete 1 to 6 cycles after the ack was sampled
            d = 1 + next_rand() % 6;
            repeat (d - 1) @(posedge clk);
            job_fetch_complete <= 1'b1;
            @(posedge clk);
            job_fetch_complete <= 1'b0;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Compare process, outputs sampled on the falling edge
    ////////////////////////////////////////////////////////////////////////////
    always @(negedge clk) begin
        if (!rst) begin
            if (job_accept) accept_cnt++;
            if (job_fetch_request && !req_prev) fetch_cnt++;
            if (ce_execute[`QUAD_NUM_CE-1]) exe_cnt++;
            if (pix_seq_bram_rden) begin
                if (int'(pix_seq_bram_rdaddr) != expected_seq_addr(seq_cnt, cur_cols)) begin
                    $display("ERROR at %0t ns: read %0d at address %0d, expected %0d", $time,
                             seq_cnt, pix_seq_bram_rdaddr, expected_seq_addr(seq_cnt, cur_cols));
                    value_errs++;
                end
                seq_cnt++;
            end
            // Burst must open right after a fetch complete
            if (pfb_rden && !pfb_prev && !cmpl_prev) begin
                $display("ERROR at %0t ns: prefetch read burst without fetch complete", $time);
                value_errs++;
            end
            if (pfb_rden) begin
                // Column within the row, rows finished so far
                if (int'(input_col) != burst_len || int'(input_row) != rows_read) begin
                    $display("ERROR at %0t ns: prefetch read at row %0d col %0d, %s %0d col %0d",
                             $time, input_row, input_col, "expected row", rows_read, burst_len);
                    value_errs++;
                end
                pfb_cnt++;
                burst_len++;
            end else if (pfb_prev) begin
                check_count("prefetch burst", burst_len, cur_cols + 1);
                burst_len = 0;
                rows_read++;
                // Row count steps as the burst ends
                if (int'(input_row) != rows_read) begin
                    $display("ERROR at %0t ns: input row %0d after burst, expected %0d",
                             $time, input_row, rows_read);
                    value_errs++;
                end
            end
        end
        pfb_prev  = pfb_rden;
        cmpl_prev = job_fetch_complete;
        req_prev  = job_fetch_request;
    end

    ////////////////////////////////////////////////////////////////////////////
    // One job, start to acknowledged completion
    ////////////////////////////////////////////////////////////////////////////
    task automatic run_job(input int rows, input int cols);
        int waited;
        int d;
        int exp_seq;
        exp_seq = expected_seq_reads(rows, cols);
        @(posedge clk);
        accept_cnt = 0;
        fetch_cnt  = 0;
        pfb_cnt    = 0;
        seq_cnt    = 0;
        exe_cnt    = 0;
        cur_cols   = cols;
        num_input_cols <= dim_t'(cols);
        num_input_rows <= dim_t'(rows);
        job_start      <= 1'b1;
        // Start sampled at the next edge, accept one cycle on
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
            if (waited > TIMEOUT) timeout_abort("job_accept");
        end while (!job_accept);
        check_count("cycles to job_accept", waited, 2);
        @(posedge clk);
        job_start <= 1'b0;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
            if (waited > TIMEOUT) timeout_abort("job_complete");
        end while (!job_complete);
        // Chain must be empty by now
        if (exe_cnt != exp_seq || ce_execute != '0) begin
            $display("ERROR at %0t ns: job_complete before last CE enable", $time);
            value_errs++;
        end
        d = next_rand() % 4;
        repeat (d) begin
            @(posedge clk);
            @(negedge clk);
            if (!job_complete) begin
                $display("ERROR at %0t ns: job_complete fell before ack", $time);
                value_errs++;
            end
        end
        @(posedge clk);
        job_complete_ack <= 1'b1;
        @(posedge clk);
        job_complete_ack <= 1'b0;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
            if (waited > TIMEOUT) timeout_abort("job_complete to fall");
        end while (job_complete);
        check_count("cycles to job_complete low", waited, 1);
        check_count("job_accept", accept_cnt, 1);
        check_count("fetch", fetch_cnt, rows + 1);
        check_count("pfb_rden", pfb_cnt, expected_pfb_reads(rows, cols));
        check_count("sequence read", seq_cnt, exp_seq);
        check_count("last CE execute", exe_cnt, exp_seq);
    endtask

    initial begin : main_seq
        rst                = 1'b1;
        num_input_cols     = '0;
        num_input_rows     = '0;
        job_start          = 1'b0;
        job_fetch_ack      = 1'b0;
        job_fetch_complete = 1'b0;
        job_complete_ack   = 1'b0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        // Quiet outputs before the first job
        repeat (4) begin
            @(negedge clk);
            if (job_accept || job_fetch_request || job_complete || pfb_rden
                || pix_seq_bram_rden || ce_execute != '0) begin
                $display("ERROR at %0t ns: control output active before any job", $time);
                value_errs++;
            end
        end
        for (int j = 0; j < NUM_JOBS; j++) begin
            run_job(job_rows[j], job_cols[j]);
        end
        repeat (20) @(posedge clk);
        finish_run();
    end

endmodule

/* quad_ctrl_props.sv */
`timescale 1ns/10ps
`include "quad_ctrl_consts.svh"

module quad_ctrl_props import quad_ctrl_pkg::*; (
    input logic clk,
    input logic rst,
    input logic job_accept,
    input logic job_fetch_request,
    input logic job_fetch_ack,
    input logic job_complete,
    input logic job_complete_ack,
    input logic pix_seq_bram_rden,
    input logic [`QUAD_NUM_CE-1:0] ce_execute,
    input ctrl_state_t seq_state
);

    // Failure tally, read from the testbench top
    int assert_fails = 0;

    function automatic void flag_failure(input string what);
        assert_fails++;
        $error("%s", what);
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Handshakes
    ////////////////////////////////////////////////////////////////////////////
    // Request held until ack
    req_held: assert property (@(posedge clk) disable iff (rst)
        job_fetch_request && !job_fetch_ack |=> job_fetch_request)
        else flag_failure("fetch request fell without ack");

    // Low the cycle after ack
    req_dropped: assert property (@(posedge clk) disable iff (rst)
        job_fetch_request && job_fetch_ack |=> !job_fetch_request)
        else flag_failure("fetch request still high after ack");

    cmpl_held: assert property (@(posedge clk) disable iff (rst)
        job_complete && !job_complete_ack |=> job_complete)
        else flag_failure("job complete fell without ack");

    accept_pulse: assert property (@(posedge clk) disable iff (rst)
        job_accept |=> !job_accept)
        else flag_failure("job accept longer than one cycle");

    // Sequence reads only while the FSM sweeps
    rd_in_sweep: assert property (@(posedge clk) disable iff (rst)
        pix_seq_bram_rden |-> seq_state == st_sweep)
        else flag_failure("sequence read outside a sweep");

    ////////////////////////////////////////////////////////////////////////////
    // Execute chain timing
    ////////////////////////////////////////////////////////////////////////////
    // First CE trails the read strobe by the BRAM latency
    exe_first: assert property (@(posedge clk) disable iff (rst)
        ce_execute[0] == $past(pix_seq_bram_rden, `QUAD_SEQ_RD_LAT))
        else flag_failure("first CE enable off the read latency");

    for (genvar i = 1; i < `QUAD_NUM_CE; i++) begin : g_step
        exe_step: assert property (@(posedge clk) disable iff (rst)
            ce_execute[i] == $past(ce_execute[i-1]))
            else flag_failure("CE enable chain step broken");
    end

endmodule

/* quad_bram_ctrl.sv */
`timescale 1ns/10ps
`include "quad_ctrl_consts.svh"

module quad_bram_ctrl import quad_ctrl_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  dim_t num_input_cols,
    input  dim_t num_input_rows,
    input  logic job_start,
    output logic job_accept,
    output logic job_fetch_request,
    input  logic job_fetch_ack,
    input  logic job_fetch_complete,
    output logic job_complete,
    input  logic job_complete_ack,
    output dim_t input_row,
    output dim_t input_col,
    output logic pfb_rden,
    output logic pix_seq_bram_rden,
    output seq_addr_t pix_seq_bram_rdaddr,
    output logic [`QUAD_NUM_CE-1:0] ce_execute
);

    row_load_if  load_bus ();
    row_sweep_if sweep_bus ();

    // Execute chain still holds strobes
    logic chain_busy;

    assign input_row = load_bus.in_row;

    ////////////////////////////////////////////////////////////////////////////
    // Job control, then row reads, sequence reads and CE enables
    ////////////////////////////////////////////////////////////////////////////
    job_sequencer u_seq (
        .clk                (clk),
        .rst                (rst),
        .num_input_cols     (num_input_cols),
        .num_input_rows     (num_input_rows),
        .job_start          (job_start),
        .job_accept         (job_accept),
        .job_fetch_request  (job_fetch_request),
        .job_fetch_ack      (job_fetch_ack),
        .job_fetch_complete (job_fetch_complete),
        .job_complete       (job_complete),
        .job_complete_ack   (job_complete_ack),
        .load               (load_bus.seq),
        .sweep              (sweep_bus.seq),
        .chain_busy         (chain_busy)
    );

    pfb_row_reader u_reader (
        .clk       (clk),
        .rst       (rst),
        .load      (load_bus.reader),
        .pfb_rden  (pfb_rden),
        .input_col (input_col)
    );

    pix_seq_issuer u_issuer (
        .clk                 (clk),
        .rst                 (rst),
        .sweep               (sweep_bus.issuer),
        .pix_seq_bram_rden   (pix_seq_bram_rden),
        .pix_seq_bram_rdaddr (pix_seq_bram_rdaddr)
    );

    ce_execute_chain u_chain (
        .clk        (clk),
        .rst        (rst),
        .rd_strobe  (pix_seq_bram_rden),
        .ce_execute (ce_execute),
        .busy       (chain_busy)
    );

endmodule

/* ce_execute_chain.sv */
`timescale 1ns/10ps
`include "quad_ctrl_consts.svh"

module ce_execute_chain (
    input  logic clk,
    input  logic rst,
    input  logic rd_strobe,
    output logic [`QUAD_NUM_CE-1:0] ce_execute,
    output logic busy
);

    // Covers the sequence BRAM read latency
    logic [`QUAD_SEQ_RD_LAT-1:0] rd_dly;
    // Execute enables past the first CE
    logic [`QUAD_NUM_CE-1:1] exe_q;

    assign ce_execute = {exe_q, rd_dly[`QUAD_SEQ_RD_LAT-1]};

    // Any strobe still in flight
    assign busy = (|rd_dly) || (|exe_q);

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_dly <= '0;
            exe_q  <= '0;
        end else begin
            rd_dly <= {rd_dly[`QUAD_SEQ_RD_LAT-2:0], rd_strobe};
            exe_q  <= ce_execute[`QUAD_NUM_CE-2:0];
        end
    end

endmodule

/* pix_seq_issuer.sv */
`timescale 1ns/10ps
`include "quad_ctrl_consts.svh"

module pix_seq_issuer import quad_ctrl_pkg::*; (
    input  logic clk,
    input  logic rst,
    row_sweep_if.issuer sweep,
    output logic pix_seq_bram_rden,
    output seq_addr_t pix_seq_bram_rdaddr
);

    localparam int CYC_W = $clog2(`QUAD_READS_PER_COL);

    // Read slot within the current output column
    logic [CYC_W-1:0] cyc;
    dim_t out_col;
    // Last address of a sweep, five reads per column
    seq_addr_t addr_last;

    assign addr_last = seq_addr_t'(`QUAD_READS_PER_COL) * seq_addr_t'(sweep.num_cols)
                     + seq_addr_t'(`QUAD_READS_PER_COL - 1);

    ////////////////////////////////////////////////////////////////////////////
    // Read strobe and column counters
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            pix_seq_bram_rden <= 1'b0;
            cyc               <= '0;
            out_col           <= '0;
            sweep.out_row     <= '0;
            sweep.done        <= 1'b0;
        end else begin
            sweep.done <= 1'b0;
            if (sweep.start) begin
                pix_seq_bram_rden <= 1'b1;
            end else if (pix_seq_bram_rden) begin
                if (cyc == CYC_W'(`QUAD_READS_PER_COL - 1)) begin
                    cyc <= '0;
                    if (out_col == sweep.num_cols) begin
                        // Final column of the sweep
                        out_col           <= '0;
                        pix_seq_bram_rden <= 1'b0;
                        sweep.out_row     <= sweep.out_row + 1'b1;
                        sweep.done        <= 1'b1;
                    end else begin
                        out_col <= out_col + 1'b1;
                    end
                end else begin
                    cyc <= cyc + 1'b1;
                end
            end
        end
    end

    // One address per read, wrapping at the end of the sequence data
    always_ff @(posedge clk) begin
        if (rst) begin
            pix_seq_bram_rdaddr <= '0;
        end else if (pix_seq_bram_rden) begin
            if (pix_seq_bram_rdaddr == addr_last) begin
                pix_seq_bram_rdaddr <= '0;
            end else begin
                pix_seq_bram_rdaddr <= pix_seq_bram_rdaddr + 1'b1;
            end
        end
    end

endmodule

/* pfb_row_reader.sv */
`timescale 1ns/10ps
`include "quad_ctrl_consts.svh"

module pfb_row_reader import quad_ctrl_pkg::*; (
    input  logic clk,
    input  logic rst,
    row_load_if.reader load,
    output logic pfb_rden,
    output dim_t input_col
);

    // Words left in the prefetch buffer, up to a full row
    logic [`QUAD_DIM_W:0] occ;

    // Read while anything remains
    assign pfb_rden = (occ != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            occ <= '0;
        end else if (load.start) begin
            occ <= {1'b0, load.num_cols} + 1'b1;
        end else if (pfb_rden) begin
            occ <= occ - 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Input row and column tracking
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            input_col   <= '0;
            load.in_row <= '0;
            load.done   <= 1'b0;
        end else begin
            load.done <= 1'b0;
            if (pfb_rden) begin
                if (input_col == load.num_cols) begin
                    // End of row
                    input_col   <= '0;
                    load.in_row <= load.in_row + 1'b1;
                    load.done   <= 1'b1;
                end else begin
                    input_col <= input_col + 1'b1;
                end
            end
        end
    end

endmodule

/* job_sequencer.sv */
`timescale 1ns/10ps
`include "quad_ctrl_consts.svh"

module job_sequencer import quad_ctrl_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  dim_t num_input_cols,
    input  dim_t num_input_rows,
    input  logic job_start,
    output logic job_accept,
    output logic job_fetch_request,
    input  logic job_fetch_ack,
    input  logic job_fetch_complete,
    output logic job_complete,
    input  logic job_complete_ack,
    row_load_if.seq  load,
    row_sweep_if.seq sweep,
    input  logic chain_busy
);

    ctrl_state_t state;

    // Job dimensions, latched at accept
    dim_t cols_q;
    dim_t rows_q;

    // Reader and issuer counters run freely, so the job is counted from a base
    dim_t in_base;
    dim_t out_base;
    dim_t rows_loaded;
    dim_t sweeps_done;

    // Fetch acked, waiting for complete
    logic fetch_acked;
    // Loaded row being read out of the prefetch buffer
    logic row_busy;

    assign rows_loaded = load.in_row - in_base;
    assign sweeps_done = sweep.out_row - out_base;

    assign load.num_cols  = cols_q;
    assign sweep.num_cols = cols_q;

    // Row read starts right off the fetch complete
    assign load.start = (state == st_load) && fetch_acked && job_fetch_complete;

    always_ff @(posedge clk) begin
        if (state == st_idle && job_start) begin
            cols_q   <= num_input_cols;
            rows_q   <= num_input_rows;
            in_base  <= load.in_row;
            out_base <= sweep.out_row;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Job FSM
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            state             <= st_idle;
            job_accept        <= 1'b0;
            job_fetch_request <= 1'b0;
            job_complete      <= 1'b0;
            fetch_acked       <= 1'b0;
            row_busy          <= 1'b0;
            sweep.start       <= 1'b0;
        end else begin
            job_accept  <= 1'b0;
            sweep.start <= 1'b0;
            case (state)
                st_idle: begin
                    if (job_start) begin
                        job_accept <= 1'b1;
                        state      <= st_load;
                    end
                end
                st_load: begin
                    // Request held until acked
                    if (job_fetch_request && job_fetch_ack) begin
                        job_fetch_request <= 1'b0;
                        fetch_acked       <= 1'b1;
                    end else if (!job_fetch_request && !fetch_acked && !row_busy) begin
                        job_fetch_request <= 1'b1;
                    end
                    if (fetch_acked && job_fetch_complete) begin
                        fetch_acked <= 1'b0;
                        row_busy    <= 1'b1;
                    end
                    // Row read out, prime more or start a sweep
                    if (row_busy && load.done) begin
                        row_busy <= 1'b0;
                        if (rows_loaded >= dim_t'(`QUAD_PRIME_ROWS)) begin
                            sweep.start <= 1'b1;
                            state       <= st_sweep;
                        end
                    end
                end
                st_sweep: begin
                    if (sweep.done) begin
                        if (sweeps_done == dim_t'(rows_q + 1'b1)) begin
                            state <= st_drain;
                        end else if (rows_loaded <= rows_q) begin
                            state <= st_load;
                        end else begin
                            // Whole frame loaded, sweep again
                            sweep.start <= 1'b1;
                        end
                    end
                end
                st_drain: begin
                    if (!chain_busy) begin
                        job_complete <= 1'b1;
                        state        <= st_done;
                    end
                end
                st_done: begin
                    // Complete held until acked
                    if (job_complete_ack) begin
                        job_complete <= 1'b0;
                        state        <= st_idle;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

endmodule

/* quad_ctrl_if.sv */
`timescale 1ns/10ps

////////////////////////////////////////////////////////////////////////////
// Row load, sequencer to prefetch-buffer reader
////////////////////////////////////////////////////////////////////////////
interface row_load_if import quad_ctrl_pkg::*; ();
    // One loaded row ready for reading
    logic start;
    dim_t num_cols;
    // Last column of the row read
    logic done;
    // Rows read so far
    dim_t in_row;

    modport seq (output start, output num_cols, input done, input in_row);
    modport reader (input start, input num_cols, output done, output in_row);
endinterface

////////////////////////////////////////////////////////////////////////////
// Row sweep, sequencer to sequence-read issuer
////////////////////////////////////////////////////////////////////////////
interface row_sweep_if import quad_ctrl_pkg::*; ();
    // Begins one output-row sweep
    logic start;
    dim_t num_cols;
    // Last read of the sweep issued
    logic done;
    // Completed output rows
    dim_t out_row;

    modport seq (output start, output num_cols, input done, input out_row);
    modport issuer (input start, input num_cols, output done, output out_row);
endinterface

/* quad_ctrl_pkg.sv */
`include "quad_ctrl_consts.svh"

package quad_ctrl_pkg;

    // Row or column index
    typedef logic [`QUAD_DIM_W-1:0] dim_t;

    // Pixel-sequence BRAM address
    typedef logic [`QUAD_ADDR_W-1:0] seq_addr_t;

    // One-hot job state
    typedef enum logic [4:0] {
        st_idle  = 5'b00001,
        st_load  = 5'b00010,
        st_sweep = 5'b00100,
        st_drain = 5'b01000,
        st_done  = 5'b10000
    } ctrl_state_t;

endpackage

/* quad_ctrl_consts.svh */
`ifndef QUAD_CTRL_CONSTS_SVH
`define QUAD_CTRL_CONSTS_SVH

// Compute elements fed by the execute chain
`define QUAD_NUM_CE 8

// Pixel-sequence BRAM read latency in cycles
`define QUAD_SEQ_RD_LAT 3

// Sequence reads issued per output column
`define QUAD_READS_PER_COL 5

// Input rows loaded before the first sweep
`define QUAD_PRIME_ROWS 4

// Row/column index width, half of a 1024 deep BRAM
`define QUAD_DIM_W 9

// Sequence BRAM address width
`define QUAD_ADDR_W 12

`endif
